/* Makefile */
TOP := snake_game_tb

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then \
		echo "Simulation failed"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* files.f */
+incdir+rtl
rtl/snake_pkg.sv
rtl/segment_ram.sv
rtl/snake_body.sv
rtl/snake_regs.sv
rtl/snake_game_top.sv
verif/snake_game_chk.sv
verif/snake_game_tb.sv

/* rtl/segment_ram.sv */
`timescale 1ns/1ps
`include "snake_cfg.svh"

module segment_ram #(
	parameter type payload_t = snake_pkg::seg_t,
	parameter int DEPTH = `SNAKE_MAX_LEN
) (
	input  logic                          clk,
	input  logic                          we,
	input  logic [snake_pkg::IDX_BITS-1:0] waddr,
	input  payload_t                      wdata,
	input  logic [snake_pkg::IDX_BITS-1:0] raddr,
	output payload_t                      rdata
);

	localparam int IW = snake_pkg::IDX_BITS;
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [IW-1:0] LAST = IW'(DEPTH - 1);

	payload_t mem [DEPTH];

	//////////////////////
	// Write port
	//////////////////////

	// Addresses past the array are dropped
	always_ff @(posedge clk) begin
		if (we && waddr <= LAST)
			mem[waddr[AW-1:0]] <= wdata;
	end

	//////////////////////
	// Read port
	//////////////////////

	// Registered read with data one cycle after raddr
	always_ff @(posedge clk) begin
		rdata <= mem[raddr[AW-1:0]];
	end

endmodule

/* rtl/snake_body.sv */
`timescale 1ns/1ps
`include "snake_cfg.svh"

module snake_body (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           step_req,
	input  logic                           grow,
	input  snake_pkg::dir_t                dir,
	input  logic                           seg_rd_req,
	input  logic [snake_pkg::IDX_BITS-1:0] seg_rd_idx,
	output logic                           seg_rd_valid,
	output snake_pkg::seg_t                seg_rd_data,
	output logic                           busy,
	output logic                           collide,
	output logic [snake_pkg::IDX_BITS-1:0] length,
	output snake_pkg::seg_t                head,
	output logic                           ram_we,
	output logic [snake_pkg::IDX_BITS-1:0] ram_waddr,
	output logic [snake_pkg::IDX_BITS-1:0] ram_raddr,
	output snake_pkg::seg_t                ram_wdata,
	input  snake_pkg::seg_t                ram_rdata
);

	localparam int IW = snake_pkg::IDX_BITS;
	localparam int CW = IW + 1;
	localparam int XW = snake_pkg::X_BITS;
	localparam int YW = snake_pkg::Y_BITS;
	localparam snake_pkg::seg_t CENTER = '{x: XW'(`SNAKE_H / 2), y: YW'(`SNAKE_V / 2)};

	logic            init;
	logic            walking;
	logic [CW-1:0]   cnt;
	logic [CW-1:0]   len_ext;
	logic            step_go;
	logic            grow_eff;
	logic            keep;
	logic            d_valid;
	logic [IW-1:0]   d_idx;
	snake_pkg::seg_t d_reg;
	snake_pkg::seg_t new_head;
	snake_pkg::seg_t next_head;
	logic            rd_pend;
	logic            rd_issue;

	assign busy    = init | walking;
	assign len_ext = CW'(length);
	assign step_go = step_req & ~busy & ~collide;

	// Returned segment at cnt is old index cnt-1; the tail survives only on growth
	assign keep = walking && cnt != '0 &&
		(cnt < len_ext || (cnt == len_ext && grow_eff));

	// One step in the requested direction, wrapping on the grid
	always_comb begin
		next_head = head;
		case (dir)
			snake_pkg::DIR_RIGHT: next_head.x = head.x + 1'b1;
			snake_pkg::DIR_UP:    next_head.y = head.y + 1'b1;
			snake_pkg::DIR_LEFT:  next_head.x = head.x - 1'b1;
			snake_pkg::DIR_DOWN:  next_head.y = head.y - 1'b1;
			default:              next_head = head;
		endcase
	end

	//////////////////////
	// Walk control
	//////////////////////

	// Walk lasts length+3 cycles; head and length commit on the last one
	always_ff @(posedge clk) begin
		if (reset) begin
			init     <= 1'b1;
			walking  <= 1'b0;
			cnt      <= '0;
			length   <= IW'(1);
			head     <= CENTER;
			collide  <= 1'b0;
			grow_eff <= 1'b0;
			d_valid  <= 1'b0;
		end else begin
			init    <= 1'b0;
			d_valid <= keep;
			if (keep && ram_rdata == new_head)
				collide <= 1'b1;
			if (step_go) begin
				walking  <= 1'b1;
				cnt      <= '0;
				grow_eff <= grow && (length < IW'(`SNAKE_MAX_LEN));
			end else if (walking) begin
				if (cnt == len_ext + CW'(2)) begin
					walking <= 1'b0;
					head    <= new_head;
					if (grow_eff)
						length <= length + 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// Pipeline payload
	always_ff @(posedge clk) begin
		if (step_go)
			new_head <= next_head;
		if (keep) begin
			d_reg <= ram_rdata;
			d_idx <= cnt[IW-1:0];
		end
		if (rd_pend)
			seg_rd_data <= ram_rdata;
	end

	//////////////////////
	// RAM ports
	//////////////////////

	// Head goes to index 0 once index 0 has been read out
	always_comb begin
		ram_we    = 1'b0;
		ram_waddr = '0;
		ram_wdata = d_reg;
		if (init) begin
			ram_we    = 1'b1;
			ram_wdata = CENTER;
		end else if (walking && cnt == CW'(1)) begin
			ram_we    = 1'b1;
			ram_wdata = new_head;
		end else if (d_valid) begin
			ram_we    = 1'b1;
			ram_waddr = d_idx;
		end
	end

	// Walk owns the read port; host reads wait for idle
	assign ram_raddr = (walking && cnt < len_ext) ? cnt[IW-1:0] : seg_rd_idx;
	assign rd_issue  = seg_rd_req & ~busy & ~rd_pend & ~seg_rd_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_pend      <= 1'b0;
			seg_rd_valid <= 1'b0;
		end else begin
			rd_pend      <= rd_issue;
			seg_rd_valid <= rd_pend;
		end
	end

endmodule

/* rtl/snake_cfg.svh */
`ifndef SNAKE_CFG_SVH
`define SNAKE_CFG_SVH

//////////////////////
// Playfield
//////////////////////

// Grid size in cells as powers of two so coordinates wrap for free
`define SNAKE_H 32
`define SNAKE_V 32

//////////////////////
// Storage and bus
//////////////////////

// Segment RAM capacity and so the length cap
`define SNAKE_MAX_LEN 64

`define SNAKE_APB_AW 5

`endif

/* rtl/snake_game_top.sv */
`timescale 1ns/1ps
`include "snake_cfg.svh"

module snake_game_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [`SNAKE_APB_AW-1:0] paddr,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  logic [31:0]              pwdata,
	output logic [31:0]              prdata,
	output logic                     pready,
	output logic                     pslverr
);

	localparam int IW = snake_pkg::IDX_BITS;

	// Host side
	logic            step_req;
	logic            grow;
	snake_pkg::dir_t dir;
	logic            seg_rd_req;
	logic [IW-1:0]   seg_rd_idx;
	logic            seg_rd_valid;
	snake_pkg::seg_t seg_rd_data;
	logic            busy;
	logic            collide;
	logic [IW-1:0]   length;
	snake_pkg::seg_t head;

	// Memory side
	logic            ram_we;
	logic [IW-1:0]   ram_waddr;
	logic [IW-1:0]   ram_raddr;
	snake_pkg::seg_t ram_wdata;
	snake_pkg::seg_t ram_rdata;

	snake_regs u_regs (.clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
		.pready, .pslverr, .step_req, .grow, .dir, .seg_rd_req, .seg_rd_idx, .seg_rd_valid,
		.seg_rd_data, .busy, .collide, .length, .head);

	snake_body u_body (.clk, .reset, .step_req, .grow, .dir, .seg_rd_req, .seg_rd_idx,
		.seg_rd_valid, .seg_rd_data, .busy, .collide, .length, .head, .ram_we, .ram_waddr,
		.ram_raddr, .ram_wdata, .ram_rdata);

	segment_ram #(
		.payload_t(snake_pkg::seg_t),
		.DEPTH(`SNAKE_MAX_LEN)
	) u_ram (
		.clk(clk),
		.we(ram_we),
		.waddr(ram_waddr),
		.wdata(ram_wdata),
		.raddr(ram_raddr),
		.rdata(ram_rdata)
	);

endmodule

/* rtl/snake_pkg.sv */
`include "snake_cfg.svh"

package snake_pkg;

	// Coordinate widths follow the grid size
	localparam int X_BITS = $clog2(`SNAKE_H);
	localparam int Y_BITS = $clog2(`SNAKE_V);

	// Index must also hold the value SNAKE_MAX_LEN itself
	localparam int IDX_BITS = $clog2(`SNAKE_MAX_LEN + 1);

	typedef enum logic [1:0] {
		DIR_RIGHT = 2'd0,
		DIR_UP    = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_DOWN  = 2'd3
	} dir_t;

	// One cell of the body with x in the upper bits
	typedef struct packed {
		logic [X_BITS-1:0] x;
		logic [Y_BITS-1:0] y;
	} seg_t;

	// APB register map
	localparam logic [`SNAKE_APB_AW-1:0] REG_CTRL     = `SNAKE_APB_AW'(8'h00);
	localparam logic [`SNAKE_APB_AW-1:0] REG_STATUS   = `SNAKE_APB_AW'(8'h04);
	localparam logic [`SNAKE_APB_AW-1:0] REG_HEAD     = `SNAKE_APB_AW'(8'h08);
	localparam logic [`SNAKE_APB_AW-1:0] REG_SEG_IDX  = `SNAKE_APB_AW'(8'h0C);
	localparam logic [`SNAKE_APB_AW-1:0] REG_SEG_DATA = `SNAKE_APB_AW'(8'h10);

endpackage

/* rtl/snake_regs.sv */
`timescale 1ns/1ps
`include "snake_cfg.svh"

module snake_regs (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [`SNAKE_APB_AW-1:0]       paddr,
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [31:0]                    pwdata,
	output logic [31:0]                    prdata,
	output logic                           pready,
	output logic                           pslverr,
	output logic                           step_req,
	output logic                           grow,
	output snake_pkg::dir_t                dir,
	output logic                           seg_rd_req,
	output logic [snake_pkg::IDX_BITS-1:0] seg_rd_idx,
	input  logic                           seg_rd_valid,
	input  snake_pkg::seg_t                seg_rd_data,
	input  logic                           busy,
	input  logic                           collide,
	input  logic [snake_pkg::IDX_BITS-1:0] length,
	input  snake_pkg::seg_t                head
);

	localparam int IW = snake_pkg::IDX_BITS;

	logic        setup;
	logic        wr_done;
	logic        err;
	logic        busy_now;
	logic [31:0] rd_data;

	assign setup    = psel & ~penable;
	assign wr_done  = psel & penable & pwrite & ~pslverr;
	// A step already issued counts as busy before the walker reacts
	assign busy_now = busy | step_req;

	//////////////////////
	// Decode
	//////////////////////

	always_comb begin
		err     = 1'b0;
		rd_data = '0;
		case (paddr)
			snake_pkg::REG_CTRL: begin
				rd_data = {28'd0, grow, 1'b0, dir};
				err     = pwrite && pwdata[2] && (busy_now || collide);
			end
			snake_pkg::REG_STATUS:
				rd_data = {16'd0, 8'(length), 6'd0, collide, busy_now};
			snake_pkg::REG_HEAD:
				rd_data = 32'(head);
			snake_pkg::REG_SEG_IDX: begin
				rd_data = 32'(seg_rd_idx);
				err     = pwrite && (pwdata >= 32'(length));
			end
			snake_pkg::REG_SEG_DATA:
				err = !pwrite && (seg_rd_idx >= length);
			default:
				err = 1'b1;
		endcase
	end

	//////////////////////
	// Transfer control
	//////////////////////

	// pready is registered from the setup phase; segment reads hold it low
	always_ff @(posedge clk) begin
		if (reset) begin
			pready     <= 1'b0;
			pslverr    <= 1'b0;
			step_req   <= 1'b0;
			seg_rd_req <= 1'b0;
			seg_rd_idx <= '0;
			dir        <= snake_pkg::DIR_RIGHT;
			grow       <= 1'b0;
		end else begin
			step_req <= 1'b0;
			if (pready) begin
				// Access phase completes here
				pready  <= 1'b0;
				pslverr <= 1'b0;
				if (wr_done) begin
					case (paddr)
						snake_pkg::REG_CTRL: begin
							dir      <= snake_pkg::dir_t'(pwdata[1:0]);
							grow     <= pwdata[3];
							step_req <= pwdata[2];
						end
						snake_pkg::REG_SEG_IDX:
							seg_rd_idx <= pwdata[IW-1:0];
						default: ;
					endcase
				end
			end else if (seg_rd_req) begin
				if (seg_rd_valid) begin
					seg_rd_req <= 1'b0;
					pready     <= 1'b1;
				end
			end else if (setup) begin
				if (!pwrite && paddr == snake_pkg::REG_SEG_DATA && !err) begin
					seg_rd_req <= 1'b1;
				end else begin
					pready  <= 1'b1;
					pslverr <= err;
				end
			end
		end
	end

	// Read data
	always_ff @(posedge clk) begin
		if (setup && !pwrite)
			prdata <= rd_data;
		else if (seg_rd_req && seg_rd_valid)
			prdata <= 32'(seg_rd_data);
	end

endmodule

/* verif/snake_game_chk.sv */
`timescale 1ns/1ps
`include "snake_cfg.svh"

module snake_game_chk (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [`SNAKE_APB_AW-1:0]       paddr,
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [31:0]                    pwdata,
	input  logic                           pready,
	input  logic                           step_req,
	input  logic                           busy,
	input  logic                           collide,
	input  logic [snake_pkg::IDX_BITS-1:0] length
);

	logic       in_walk;
	logic [7:0] busy_cnt;
	logic [7:0] walk_len;
	// Failed assertions so far
	int         fail_count = 0;

	// Busy cycles of the walk in progress counted against the length at the step
	always_ff @(posedge clk) begin
		if (reset) begin
			in_walk  <= 1'b0;
			busy_cnt <= '0;
			walk_len <= '0;
		end else if (step_req) begin
			in_walk  <= 1'b1;
			busy_cnt <= '0;
			walk_len <= 8'(length) + 8'd3;
		end else if (in_walk) begin
			if (busy)
				busy_cnt <= busy_cnt + 8'd1;
			else
				in_walk <= 1'b0;
		end
	end

	//////////////////////
	// APB
	//////////////////////

	apb_hold: assert property (@(posedge clk) disable iff (reset)
		$past(psel && penable && !pready) |->
			psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
		else begin
			fail_count++;
			$error("APB request changed while pready was low");
		end

	ready_reset: assert property (@(posedge clk) $past(reset) |-> !pready)
		else begin
			fail_count++;
			$error("pready high right after reset");
		end

	//////////////////////
	// Walker
	//////////////////////

	busy_start: assert property (@(posedge clk) disable iff (reset)
		$past(step_req) |-> busy)
		else begin
			fail_count++;
			$error("busy did not rise after a step request");
		end

	busy_len: assert property (@(posedge clk) disable iff (reset)
		(in_walk && !busy) |-> busy_cnt == walk_len)
		else begin
			fail_count++;
			$error("busy did not last length + 3 cycles");
		end

	len_grow: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> length >= $past(length))
		else begin
			fail_count++;
			$error("length decreased");
		end

	collide_sticky: assert property (@(posedge clk) disable iff (reset)
		(!$past(reset) && $past(collide)) |-> collide)
		else begin
			fail_count++;
			$error("collision flag cleared without reset");
		end

endmodule

/* verif/snake_game_tb.sv */
`timescale 1ns/1ps
`include "snake_cfg.svh"

module snake_game_tb;

	localparam int XB = snake_pkg::X_BITS;
	localparam int YB = snake_pkg::Y_BITS;
	localparam int SW = XB + YB;
	localparam int AW = `SNAKE_APB_AW;
	// Longest walk plus a full segment dump per step and some margin
	localparam int STEP_CYCLES = `SNAKE_MAX_LEN + 3 + `SNAKE_MAX_LEN * 12 + 40;
	localparam int STEP_COUNT = 100;

	logic          clk;
	logic          reset;
	logic [AW-1:0] paddr;
	logic          psel;
	logic          penable;
	logic          pwrite;
	logic [31:0]   pwdata;
	logic [31:0]   prdata;
	logic          pready;
	logic          pslverr;

	int            checks;
	int            mismatches;
	int            failures;
	int            assert_fails;
	integer        seed;
	// Snake model with the head at index 0
	logic [SW-1:0] body[$];
	logic          model_collide;
	logic [31:0]   data;
	logic          err;
	logic [1:0]    d;
	logic [1:0]    last;
	logic          g;

	snake_game_top u_snake_game_top (.clk, .reset, .paddr, .psel, .penable, .pwrite,
		.pwdata, .prdata, .pready, .pslverr);

	bind snake_game_top snake_game_chk u_chk (.clk(clk), .reset(reset), .paddr(paddr),
		.psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .pready(pready),
		.step_req(step_req), .busy(busy), .collide(collide), .length(length));

	always #4 clk = ~clk;

	initial begin
		#(STEP_COUNT * STEP_CYCLES * 8);
		$display("Timeout: the run did not finish within %0d steps of cycles", STEP_COUNT);
		$display("Errors found");
		$finish;
	end

	//////////////////////
	// APB master
	//////////////////////

	task automatic apb_xfer(input logic wr, input logic [AW-1:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic slverr, output int waits);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		waits   = 0;
		while (!pready) begin
			@(negedge clk);
			waits++;
		end
		rdata  = prdata;
		slverr = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic reg_write(input logic [AW-1:0] addr, input logic [31:0] wdata,
			output logic slverr);
		logic [31:0] rdata;
		int          waits;
		apb_xfer(1'b1, addr, wdata, rdata, slverr, waits);
	endtask

	task automatic reg_read(input logic [AW-1:0] addr, output logic [31:0] rdata,
			output logic slverr);
		int waits;
		apb_xfer(1'b0, addr, 32'd0, rdata, slverr, waits);
	endtask

	//////////////////////
	// Checks
	//////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			mismatches++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic ok);
		checks++;
		assert (ok) else begin
			failures++;
			$display("Error at %0t: %s", $time, what);
		end
	endtask

	task automatic check_state();
		logic [31:0] rdata;
		logic        slverr;
		reg_read(snake_pkg::REG_STATUS, rdata, slverr);
		check_value("status", rdata, {16'd0, 8'(body.size()), 6'd0, model_collide, 1'b0});
		reg_read(snake_pkg::REG_HEAD, rdata, slverr);
		check_value("head", rdata, 32'(body[0]));
	endtask

	task automatic check_segments();
		logic [31:0] rdata;
		logic        slverr;
		int          waits;
		for (int i = 0; i < body.size(); i++) begin
			apb_xfer(1'b1, snake_pkg::REG_SEG_IDX, 32'(i), rdata, slverr, waits);
			apb_xfer(1'b0, snake_pkg::REG_SEG_DATA, 32'd0, rdata, slverr, waits);
			check_flag("segment read returned pslverr", !slverr);
			check_flag("segment read completed without wait states", waits > 0);
			check_value($sformatf("segment[%0d]", i), rdata, 32'(body[i]));
		end
	endtask

	//////////////////////
	// Snake model
	//////////////////////

	function automatic logic [SW-1:0] move_head(input logic [SW-1:0] h, input logic [1:0] dr);
		int x;
		int y;
		x = int'(h[SW-1:YB]);
		y = int'(h[YB-1:0]);
		case (dr)
			2'd0: x = (x + 1) % `SNAKE_H;
			2'd1: y = (y + 1) % `SNAKE_V;
			2'd2: x = (x + `SNAKE_H - 1) % `SNAKE_H;
			default: y = (y + `SNAKE_V - 1) % `SNAKE_V;
		endcase
		return {XB'(x), YB'(y)};
	endfunction

	task automatic reset_dut();
		@(negedge clk);
		reset = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		body.delete();
		body.push_back({XB'(`SNAKE_H / 2), YB'(`SNAKE_V / 2)});
		model_collide = 1'b0;
	endtask

	task automatic wait_idle();
		logic [31:0] rdata;
		logic        slverr;
		rdata = 32'd1;
		while (rdata[0])
			reg_read(snake_pkg::REG_STATUS, rdata, slverr);
	endtask

	// Writes the step and applies the same step to the model
	task automatic issue_step(input logic [1:0] dr, input logic grow);
		logic [SW-1:0] nh;
		logic          grow_eff;
		logic          hit;
		logic          slverr;
		int            len;
		len      = body.size();
		nh       = move_head(body[0], dr);
		grow_eff = grow && (len < `SNAKE_MAX_LEN);
		hit      = 1'b0;
		for (int i = 0; i < len; i++)
			if (body[i] == nh && (i < len - 1 || grow_eff))
				hit = 1'b1;
		reg_write(snake_pkg::REG_CTRL, {28'd0, grow, 1'b1, dr}, slverr);
		if (model_collide) begin
			check_flag("step after a collision was accepted", slverr);
		end else begin
			check_flag("valid step was refused with pslverr", !slverr);
			body.push_front(nh);
			if (!grow_eff)
				void'(body.pop_back());
			model_collide = hit;
		end
	endtask

	task automatic do_step(input logic [1:0] dr, input logic grow);
		issue_step(dr, grow);
		wait_idle();
		check_state();
	endtask

	//////////////////////
	// Stimulus
	//////////////////////

	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		paddr        = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = '0;
		checks       = 0;
		mismatches   = 0;
		failures     = 0;
		assert_fails = 0;
		seed         = 32'h9d6d;
		reset_dut();
		wait_idle();
		check_state();
		check_segments();

		// All four directions, crossing every edge
		repeat (16) do_step(2'd0, 1'b0);
		repeat (16) do_step(2'd1, 1'b0);
		do_step(2'd2, 1'b0);
		do_step(2'd3, 1'b0);

		// Growth up to length 5
		repeat (4) begin
			do_step(2'd0, 1'b1);
			check_segments();
		end

		// Refused requests
		issue_step(2'd0, 1'b0);
		reg_write(snake_pkg::REG_CTRL, {28'd0, 1'b1, 1'b1, 2'd1}, err);
		check_flag("step while busy was accepted", err);
		wait_idle();
		check_state();
		reg_read(AW'(8'h14), data, err);
		check_flag("read of an unmapped address was accepted", err);
		reg_write(AW'(8'h1C), 32'hffff_ffff, err);
		check_flag("write to an unmapped address was accepted", err);
		reg_write(snake_pkg::REG_SEG_IDX, 32'd0, err);
		reg_write(snake_pkg::REG_SEG_IDX, 32'(body.size()), err);
		check_flag("segment index at the length was accepted", err);
		reg_read(snake_pkg::REG_SEG_IDX, data, err);
		check_value("seg_idx", data, 32'd0);
		check_state();
		check_segments();

		// Up, left, down lands the head on its own body
		do_step(2'd1, 1'b1);
		do_step(2'd2, 1'b1);
		do_step(2'd3, 1'b1);
		reg_read(snake_pkg::REG_STATUS, data, err);
		check_value("collide", 32'(data[1]), 32'd1);
		do_step(2'd0, 1'b0);
		check_segments();

		// Random walk without reversal
		reset_dut();
		wait_idle();
		check_state();
		last = 2'd0;
		repeat (40) begin
			d = 2'($random(seed));
			if (d == (last ^ 2'd2))
				d = last;
			g = (2'($random(seed)) == 2'd0);
			do_step(d, g);
			check_segments();
			last = d;
		end

		assert_fails = u_snake_game_top.u_chk.fail_count;
		$display("Checks: %0d, mismatches: %0d, other errors: %0d, assertion failures: %0d",
			checks, mismatches, failures, assert_fails);
		if (mismatches == 0 && failures == 0 && assert_fails == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
